/* filelist.f */
adrv_pkg.sv
adrv_axil_slave.sv
adrv_regs.sv
adrv_enable_seq.sv
adrv_spi_master.sv
adrv_ctrl_top.sv
tb_clk_gen.sv
tb_adrv_ctrl_top.sv

/* Bender.yml */
package:
  name: adrv_ctrl

sources:
  - adrv_pkg.sv
  - adrv_axil_slave.sv
  - adrv_regs.sv
  - adrv_enable_seq.sv
  - adrv_spi_master.sv
  - adrv_ctrl_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_adrv_ctrl_top.sv

/* tb_adrv_ctrl_top.sv */
`timescale 1ns/1ps

module tb_adrv_ctrl_top;

  typedef logic [adrv_pkg::ADDR_W-1:0] addr_t;

  localparam int TCK        = 8;
  localparam int DRV_DLY    = 1;
  localparam int MAX_CYCLES = 3000;  // longest run is well under 1000 cycles
  localparam int unsigned SEED = 32'hc74a_6f8f;

  logic                         s_axi_aclk;
  logic                         reset_i;
  addr_t                        awaddr_i;
  logic                         awvalid_i;
  logic                         awready_o;
  logic [31:0]                  wdata_i;
  logic [3:0]                   wstrb_i;
  logic                         wvalid_i;
  logic                         wready_o;
  logic [1:0]                   bresp_o;
  logic                         bvalid_o;
  logic                         bready_i;
  addr_t                        araddr_i;
  logic                         arvalid_i;
  logic                         arready_o;
  logic [31:0]                  rdata_o;
  logic [1:0]                   rresp_o;
  logic                         rvalid_o;
  logic                         rready_i;
  logic                         rx1_pl_en_i;
  logic                         rx2_pl_en_i;
  logic                         tx1_pl_en_i;
  logic                         tx2_pl_en_i;
  logic                         rx1_en_o;
  logic                         rx2_en_o;
  logic                         tx1_en_o;
  logic                         tx2_en_o;
  logic                         rstn_o;
  logic [adrv_pkg::DGPIO_W-1:0] dgpio_i;
  logic [adrv_pkg::DGPIO_W-1:0] dgpio_o;
  logic [adrv_pkg::DGPIO_W-1:0] dgpio_t_o;
  logic                         spi_clk_o;
  logic                         spi_mosi_o;
  logic                         spi_csn_o;
  logic                         spi_miso_i;
  logic                         spi_irq_o;

  logic [3:0] pl_en;
  logic [3:0] en_vec;
  logic [3:0] en_last = '0;
  int         en_t [4];     // time of last en_o change per channel
  int         wr_t;         // edge where the last write landed
  int         sclk_rises = 0;
  int         irq_cnt = 0;
  int         cyc = 0;
  int         checks = 0;
  int         errors = 0;

  tb_clk_gen u_clk_gen (.clk_o(s_axi_aclk), .rst_o(reset_i));

  adrv_ctrl_top u_adrv_ctrl_top (.*);

  assign spi_miso_i = spi_mosi_o;  // loopback
  assign {tx2_pl_en_i, tx1_pl_en_i, rx2_pl_en_i, rx1_pl_en_i} = pl_en;
  assign en_vec = {tx2_en_o, tx1_en_o, rx2_en_o, rx1_en_o};

  always @(en_vec) begin
    for (int i = 0; i < 4; i++)
      if (en_vec[i] !== en_last[i]) begin
        en_t[i]    = int'($time);
        en_last[i] = en_vec[i];
      end
  end

  always @(negedge spi_csn_o) sclk_rises = 0;
  always @(posedge spi_clk_o) if (spi_csn_o === 1'b0) sclk_rises++;
  always @(posedge spi_irq_o) irq_cnt++;

  always @(posedge s_axi_aclk) begin
    cyc++;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("checks %0d, errors %0d", checks, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ************************************************************
  // helpers
  // ************************************************************
  task automatic flag_error(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else flag_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge s_axi_aclk);
    #DRV_DLY;
  endtask

  task automatic write_reg(input addr_t addr, input logic [31:0] data);
    int n;
    n = 0;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = 4'hf;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    do begin
      next_cycle();
      n++;
    end while (!awready_o && n < 20);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    wr_t = int'($time) - DRV_DLY + TCK;  // register takes the word one edge later
    while (!bvalid_o && n < 20) begin
      next_cycle();
      n++;
    end
    if (n >= 20) begin
      errors++;
      $display("write handshake stalled at address %h", addr);
    end
    next_cycle();  // bready is held high
  endtask

  task automatic read_reg(input addr_t addr, output logic [31:0] data);
    int n;
    n = 0;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    do begin
      next_cycle();
      n++;
    end while (!arready_o && n < 20);
    arvalid_i = 1'b0;
    while (!rvalid_o && n < 20) begin
      next_cycle();
      n++;
    end
    data = rdata_o;
    if (n >= 20) begin
      errors++;
      $display("read handshake stalled at address %h", addr);
    end
    next_cycle();
  endtask

  task automatic wait_enable(input int ch, input logic val);
    int n;
    n = 0;
    while (en_vec[ch] !== val && n < 100) begin
      next_cycle();
      n++;
    end
    if (n >= 100) begin
      errors++;
      $display("channel %0d enable never went to %b", ch, val);
    end
  endtask

  // ************************************************************
  // protocol assertions
  // ************************************************************
  a_ready_pair: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    awready_o == wready_o) else flag_error("awready and wready split");
  a_bresp_okay: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    bvalid_o |-> bresp_o == 2'b00) else flag_error("write response not OKAY");
  a_rresp_okay: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    rvalid_o |-> rresp_o == 2'b00) else flag_error("read response not OKAY");
  a_sclk_count: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    $rose(spi_csn_o) |-> sclk_rises == 8)
    else flag_error($sformatf("spi clock rose %0d times under csn", sclk_rises));
  a_irq_at_csn: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    $rose(spi_csn_o) == spi_irq_o) else flag_error("done pulse not aligned to csn rise");
  a_irq_pulse: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    spi_irq_o |=> !spi_irq_o) else flag_error("done pulse longer than one cycle");

  // ************************************************************
  // stimulus
  // ************************************************************
  initial begin
    int unsigned seed_ret;
    logic [31:0] rd;
    logic [31:0] val;
    logic [31:0] ctrl;
    logic [7:0]  spi_byte;
    int          d_en;
    int          d_dis;
    int          ch;
    int          width;
    int          t0;

    seed_ret  = $urandom(SEED);
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    pl_en     = '0;
    dgpio_i   = '0;
    wait (!reset_i);
    next_cycle();

    // reset values and read-back
    check_eq("en after reset", en_vec, 0);
    check_eq("rstn after reset", rstn_o, 0);
    check_eq("csn after reset", spi_csn_o, 1);
    check_eq("spi clock after reset", spi_clk_o, 0);
    check_eq("bvalid, rvalid after reset", {bvalid_o, rvalid_o}, 0);
    check_eq("dgpio_t after reset", dgpio_t_o, 32'h0000_ffff);
    read_reg(adrv_pkg::REG_CTRL, rd);
    check_eq("ctrl reset value", rd, 0);
    read_reg(adrv_pkg::REG_DGPIO_DIR, rd);
    check_eq("dgpio dir reset value", rd, 32'h0000_ffff);
    for (int i = 0; i < 3; i++) begin
      val = $urandom;
      write_reg(adrv_pkg::REG_DGPIO_OUT, val);
      read_reg(adrv_pkg::REG_DGPIO_OUT, rd);
      check_eq("dgpio out read-back", rd, val & 32'h0000_ffff);
      check_eq("dgpio_o pins", dgpio_o, val & 32'h0000_ffff);
    end
    for (int i = 0; i < 4; i++) begin
      val = $urandom;
      write_reg(addr_t'(adrv_pkg::REG_DELAY_BASE + 4 * i), val);
      read_reg(addr_t'(adrv_pkg::REG_DELAY_BASE + 4 * i), rd);
      check_eq("delay read-back", rd, val);
    end
    read_reg(7'h40, rd);
    check_eq("unmapped read", rd, 0);

    // dgpio direction, input sampling, transceiver reset
    val = $urandom;
    write_reg(adrv_pkg::REG_DGPIO_DIR, val);
    check_eq("dgpio_t pins", dgpio_t_o, val & 32'h0000_ffff);
    val = $urandom;
    dgpio_i = val[15:0];
    repeat (2) next_cycle();
    read_reg(adrv_pkg::REG_DGPIO_IN, rd);
    check_eq("dgpio in read", rd, val & 32'h0000_ffff);
    write_reg(adrv_pkg::REG_CTRL, 32'h1);
    check_eq("rstn released", rstn_o, 1);
    write_reg(adrv_pkg::REG_CTRL, 32'h0);
    check_eq("rstn asserted", rstn_o, 0);
    write_reg(adrv_pkg::REG_CTRL, 32'h1);

    // software enables, one channel at a time
    for (int c = 0; c < 4; c++) begin
      d_en  = $urandom % 21;
      d_dis = $urandom % 21;
      write_reg(addr_t'(adrv_pkg::REG_DELAY_BASE + 4 * c), {d_dis[15:0], d_en[15:0]});
      ctrl = 32'h1 | (32'h100 << c);
      write_reg(adrv_pkg::REG_CTRL, ctrl);
      t0 = wr_t;
      wait_enable(c, 1'b1);
      check_eq($sformatf("ch%0d enable time", c), en_t[c], t0 + TCK * (d_en + 1));
      write_reg(adrv_pkg::REG_CTRL, 32'h1);
      t0 = wr_t;
      wait_enable(c, 1'b0);
      check_eq($sformatf("ch%0d disable time", c), en_t[c], t0 + TCK * (d_dis + 1));
    end

    // fabric pin mode with a short glitch first
    ch    = $urandom % 4;
    d_en  = 2 + $urandom % 19;
    d_dis = $urandom % 21;
    write_reg(addr_t'(adrv_pkg::REG_DELAY_BASE + 4 * ch), {d_dis[15:0], d_en[15:0]});
    ctrl = 32'h1 | (32'h10 << ch);
    write_reg(adrv_pkg::REG_CTRL, ctrl);
    read_reg(adrv_pkg::REG_CTRL, rd);
    check_eq("ctrl with mode bit", rd, ctrl);
    width = 1 + $urandom % d_en;  // never longer than the delay
    t0 = en_t[ch];  // enable must not move at all
    pl_en[ch] = 1'b1;
    repeat (width) next_cycle();
    pl_en[ch] = 1'b0;
    repeat (d_en + 4) next_cycle();
    check_eq("glitch filtered", en_t[ch], t0);
    check_eq("enable low after glitch", en_vec[ch], 0);
    pl_en[ch] = 1'b1;
    t0 = int'($time) - DRV_DLY;
    wait_enable(ch, 1'b1);
    check_eq("pin enable time", en_t[ch], t0 + TCK * (d_en + 1));
    pl_en[ch] = 1'b0;
    t0 = int'($time) - DRV_DLY;
    wait_enable(ch, 1'b0);
    check_eq("pin disable time", en_t[ch], t0 + TCK * (d_dis + 1));
    write_reg(adrv_pkg::REG_CTRL, 32'h1);

    // spi loopback, second start lands while busy
    spi_byte = 8'($urandom);
    write_reg(adrv_pkg::REG_SPI_TX, {24'h0, spi_byte});
    write_reg(adrv_pkg::REG_SPI_TX, {24'h0, ~spi_byte});
    for (int n = 0; n < 200 && !spi_irq_o; n++)
      next_cycle();
    check_eq("spi done seen", spi_irq_o, 1);
    check_eq("csn after transfer", spi_csn_o, 1);
    read_reg(adrv_pkg::REG_SPI_STAT, rd);
    check_eq("spi status", rd, {16'h0, spi_byte, 8'h02});
    repeat (100) next_cycle();
    check_eq("spi done count", irq_cnt, 1);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 4;  // 8 ns clock

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

/* adrv_ctrl_top.sv */
`timescale 1ns/1ps

module adrv_ctrl_top (
  input  logic                         s_axi_aclk,
  input  logic                         reset_i,
  input  logic [adrv_pkg::ADDR_W-1:0]  awaddr_i,
  input  logic                         awvalid_i,
  output logic                         awready_o,
  input  logic [adrv_pkg::DATA_W-1:0]  wdata_i,
  input  logic [adrv_pkg::STRB_W-1:0]  wstrb_i,
  input  logic                         wvalid_i,
  output logic                         wready_o,
  output logic [1:0]                   bresp_o,
  output logic                         bvalid_o,
  input  logic                         bready_i,
  input  logic [adrv_pkg::ADDR_W-1:0]  araddr_i,
  input  logic                         arvalid_i,
  output logic                         arready_o,
  output logic [adrv_pkg::DATA_W-1:0]  rdata_o,
  output logic [1:0]                   rresp_o,
  output logic                         rvalid_o,
  input  logic                         rready_i,
  input  logic                         rx1_pl_en_i,
  input  logic                         rx2_pl_en_i,
  input  logic                         tx1_pl_en_i,
  input  logic                         tx2_pl_en_i,
  output logic                         rx1_en_o,
  output logic                         rx2_en_o,
  output logic                         tx1_en_o,
  output logic                         tx2_en_o,
  output logic                         rstn_o,
  input  logic [adrv_pkg::DGPIO_W-1:0] dgpio_i,
  output logic [adrv_pkg::DGPIO_W-1:0] dgpio_o,
  output logic [adrv_pkg::DGPIO_W-1:0] dgpio_t_o,
  output logic                         spi_clk_o,
  output logic                         spi_mosi_o,
  output logic                         spi_csn_o,
  input  logic                         spi_miso_i,
  output logic                         spi_irq_o
);

  adrv_pkg::reg_req_t          req;
  logic [adrv_pkg::DATA_W-1:0] reg_rdata;
  adrv_pkg::chan_cfg_t         cfg [adrv_pkg::NUM_CHAN];
  adrv_pkg::spi_cmd_t          spi_cmd;
  adrv_pkg::spi_stat_t         spi_stat;
  logic [adrv_pkg::NUM_CHAN-1:0] pl_en;
  logic [adrv_pkg::NUM_CHAN-1:0] en;

  adrv_axil_slave u_axil_slave (
    .s_axi_aclk (s_axi_aclk),
    .reset_i    (reset_i),
    .awaddr_i   (awaddr_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bresp_o    (bresp_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .araddr_i   (araddr_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .req_o      (req),
    .rdata_i    (reg_rdata)
  );

  adrv_regs u_regs (
    .s_axi_aclk (s_axi_aclk),
    .reset_i    (reset_i),
    .req_i      (req),
    .rdata_o    (reg_rdata),
    .cfg_o      (cfg),
    .rstn_o     (rstn_o),
    .dgpio_i    (dgpio_i),
    .dgpio_o    (dgpio_o),
    .dgpio_t_o  (dgpio_t_o),
    .spi_cmd_o  (spi_cmd),
    .spi_stat_i (spi_stat)
  );

  // channel order rx1, rx2, tx1, tx2
  assign pl_en = {tx2_pl_en_i, tx1_pl_en_i, rx2_pl_en_i, rx1_pl_en_i};
  assign {tx2_en_o, tx1_en_o, rx2_en_o, rx1_en_o} = en;

  for (genvar i = 0; i < adrv_pkg::NUM_CHAN; i++) begin : g_chan
    adrv_enable_seq u_enable_seq (
      .s_axi_aclk (s_axi_aclk),
      .reset_i    (reset_i),
      .cfg_i      (cfg[i]),
      .pl_en_i    (pl_en[i]),
      .en_o       (en[i])
    );
  end

  adrv_spi_master u_spi_master (
    .s_axi_aclk (s_axi_aclk),
    .reset_i    (reset_i),
    .cmd_i      (spi_cmd),
    .stat_o     (spi_stat),
    .spi_clk_o  (spi_clk_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_csn_o  (spi_csn_o),
    .spi_miso_i (spi_miso_i),
    .done_o     (spi_irq_o)
  );

endmodule

/* adrv_spi_master.sv */
`timescale 1ns/1ps

module adrv_spi_master (
  input  logic                s_axi_aclk,
  input  logic                reset_i,
  input  adrv_pkg::spi_cmd_t  cmd_i,
  output adrv_pkg::spi_stat_t stat_o,
  output logic                spi_clk_o,
  output logic                spi_mosi_o,
  output logic                spi_csn_o,
  input  logic                spi_miso_i,
  output logic                done_o
);

  logic                           busy_q;
  logic                           valid_q;
  logic [adrv_pkg::SPI_DIV_W-1:0] div_q;
  logic [2:0]                     bit_q;
  logic [7:0]                     tx_sr;
  logic [7:0]                     rx_sr;

  // ************************************************************
  // control
  // ************************************************************
  always_ff @(posedge s_axi_aclk) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      valid_q   <= 1'b0;
      spi_csn_o <= 1'b1;
      spi_clk_o <= 1'b0;
      div_q     <= '0;
      bit_q     <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (!busy_q) begin
        if (cmd_i.start) begin  // start while busy is dropped
          busy_q    <= 1'b1;
          valid_q   <= 1'b0;
          spi_csn_o <= 1'b0;
          div_q     <= '0;
          bit_q     <= '0;
        end
      end else if (div_q != adrv_pkg::SPI_DIV_LAST) begin
        div_q <= div_q + 1'b1;
      end else begin
        div_q     <= '0;
        spi_clk_o <= !spi_clk_o;
        if (spi_clk_o) begin  // falling edge
          bit_q <= bit_q + 1'b1;
          if (bit_q == 3'd7) begin
            busy_q    <= 1'b0;
            valid_q   <= 1'b1;
            spi_csn_o <= 1'b1;
            done_o    <= 1'b1;
          end
        end
      end
    end
  end

  // ************************************************************
  // shift registers
  // ************************************************************
  always_ff @(posedge s_axi_aclk) begin
    if (!busy_q && cmd_i.start) begin
      tx_sr <= cmd_i.data;
    end else if (busy_q && div_q == adrv_pkg::SPI_DIV_LAST) begin
      if (spi_clk_o)
        tx_sr <= {tx_sr[6:0], 1'b0};  // next bit out on fall
      else
        rx_sr <= {rx_sr[6:0], spi_miso_i};  // sample on rise
    end
  end

  assign spi_mosi_o      = tx_sr[7];  // msb first
  assign stat_o.busy     = busy_q;
  assign stat_o.rx_valid = valid_q;
  assign stat_o.rx_data  = rx_sr;

  a_clk_idle: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    spi_csn_o |-> !spi_clk_o);

endmodule

/* adrv_enable_seq.sv */
`timescale 1ns/1ps

module adrv_enable_seq (
  input  logic                s_axi_aclk,
  input  logic                reset_i,
  input  adrv_pkg::chan_cfg_t cfg_i,
  input  logic                pl_en_i,
  output logic                en_o
);

  logic                         req;
  logic [adrv_pkg::DELAY_W-1:0] delay;
  logic [adrv_pkg::DELAY_W-1:0] cnt_q;

  assign req   = cfg_i.mode ? pl_en_i : cfg_i.sw_en;
  assign delay = req ? cfg_i.en_dly : cfg_i.dis_dly;  // rising vs falling

  always_ff @(posedge s_axi_aclk) begin
    if (reset_i) begin
      en_o  <= 1'b0;
      cnt_q <= '0;
    end else if (req == en_o) begin
      cnt_q <= '0;  // glitch gone, start over
    end else if (cnt_q == delay) begin
      en_o  <= req;
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  a_en_steady: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    req == en_o |=> $stable(en_o));

endmodule

/* adrv_regs.sv */
`timescale 1ns/1ps

module adrv_regs (
  input  logic                         s_axi_aclk,
  input  logic                         reset_i,
  input  adrv_pkg::reg_req_t           req_i,
  output logic [adrv_pkg::DATA_W-1:0]  rdata_o,
  output adrv_pkg::chan_cfg_t          cfg_o [adrv_pkg::NUM_CHAN],
  output logic                         rstn_o,
  input  logic [adrv_pkg::DGPIO_W-1:0] dgpio_i,
  output logic [adrv_pkg::DGPIO_W-1:0] dgpio_o,
  output logic [adrv_pkg::DGPIO_W-1:0] dgpio_t_o,
  output adrv_pkg::spi_cmd_t           spi_cmd_o,
  input  adrv_pkg::spi_stat_t          spi_stat_i
);

  logic [adrv_pkg::DATA_W-1:0]  ctrl_q;
  logic [adrv_pkg::DGPIO_W-1:0] dir_q;
  logic [adrv_pkg::DGPIO_W-1:0] out_q;
  logic [adrv_pkg::DGPIO_W-1:0] in_q;
  logic [adrv_pkg::DATA_W-1:0]  delay_q [adrv_pkg::NUM_CHAN];
  logic [adrv_pkg::ADDR_W-1:0]  byte_addr;
  logic                         is_delay;

  // byte strobe merge
  function automatic logic [adrv_pkg::DATA_W-1:0] wmerge(
    input logic [adrv_pkg::DATA_W-1:0] old_val,
    input logic [adrv_pkg::DATA_W-1:0] new_val,
    input logic [adrv_pkg::STRB_W-1:0] strb
  );
    logic [adrv_pkg::DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < adrv_pkg::STRB_W; b++)
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    return res;
  endfunction

  assign byte_addr = {req_i.addr, 2'b00};
  assign is_delay  = byte_addr >= adrv_pkg::REG_DELAY_BASE &&
                     byte_addr < adrv_pkg::REG_DELAY_BASE + 4 * adrv_pkg::NUM_CHAN;

  // ************************************************************
  // write side
  // ************************************************************
  always_ff @(posedge s_axi_aclk) begin
    if (reset_i) begin
      ctrl_q          <= '0;
      dir_q           <= adrv_pkg::DGPIO_DIR_RST;
      out_q           <= '0;
      spi_cmd_o.start <= 1'b0;
      for (int i = 0; i < adrv_pkg::NUM_CHAN; i++)
        delay_q[i] <= '0;
    end else begin
      spi_cmd_o.start <= req_i.we && byte_addr == adrv_pkg::REG_SPI_TX;
      if (req_i.we) begin
        case (byte_addr)
          adrv_pkg::REG_CTRL:
            ctrl_q <= wmerge(ctrl_q, req_i.data, req_i.strb) & adrv_pkg::CTRL_MASK;
          adrv_pkg::REG_DGPIO_DIR:
            dir_q <= 16'(wmerge({16'h0, dir_q}, req_i.data, req_i.strb));
          adrv_pkg::REG_DGPIO_OUT:
            out_q <= 16'(wmerge({16'h0, out_q}, req_i.data, req_i.strb));
          default:
            if (is_delay)
              delay_q[req_i.addr[1:0]] <=
                wmerge(delay_q[req_i.addr[1:0]], req_i.data, req_i.strb);
        endcase
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    in_q <= dgpio_i;  // pins sampled every cycle
    if (req_i.we && byte_addr == adrv_pkg::REG_SPI_TX)
      spi_cmd_o.data <= req_i.data[7:0];
  end

  // ************************************************************
  // read-back mux
  // ************************************************************
  always_comb begin
    rdata_o = '0;
    case (byte_addr)
      adrv_pkg::REG_CTRL:      rdata_o = ctrl_q;
      adrv_pkg::REG_DGPIO_DIR: rdata_o = {16'h0, dir_q};
      adrv_pkg::REG_DGPIO_OUT: rdata_o = {16'h0, out_q};
      adrv_pkg::REG_DGPIO_IN:  rdata_o = {16'h0, in_q};
      adrv_pkg::REG_SPI_STAT:
        rdata_o = {16'h0, spi_stat_i.rx_data, 6'h0, spi_stat_i.rx_valid, spi_stat_i.busy};
      default:
        if (is_delay) rdata_o = delay_q[req_i.addr[1:0]];
    endcase
  end

  for (genvar i = 0; i < adrv_pkg::NUM_CHAN; i++) begin : g_cfg
    assign cfg_o[i].mode    = ctrl_q[4 + i];
    assign cfg_o[i].sw_en   = ctrl_q[8 + i];
    assign cfg_o[i].en_dly  = delay_q[i][15:0];
    assign cfg_o[i].dis_dly = delay_q[i][31:16];
  end

  assign rstn_o    = ctrl_q[0];
  assign dgpio_o   = out_q;
  assign dgpio_t_o = dir_q;

  // slave must never issue both strobes at once
  a_one_req: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    !(req_i.we && req_i.re));

endmodule

/* adrv_axil_slave.sv */
`timescale 1ns/1ps

module adrv_axil_slave (
  input  logic                        s_axi_aclk,
  input  logic                        reset_i,
  input  logic [adrv_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                        awvalid_i,
  output logic                        awready_o,
  input  logic [adrv_pkg::DATA_W-1:0] wdata_i,
  input  logic [adrv_pkg::STRB_W-1:0] wstrb_i,
  input  logic                        wvalid_i,
  output logic                        wready_o,
  output logic [1:0]                  bresp_o,
  output logic                        bvalid_o,
  input  logic                        bready_i,
  input  logic [adrv_pkg::ADDR_W-1:0] araddr_i,
  input  logic                        arvalid_i,
  output logic                        arready_o,
  output logic [adrv_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                  rresp_o,
  output logic                        rvalid_o,
  input  logic                        rready_i,
  output adrv_pkg::reg_req_t          req_o,
  input  logic [adrv_pkg::DATA_W-1:0] rdata_i
);

  logic wr_rdy_q;
  logic rd_rdy_q;
  logic wr_go;
  logic rd_go;

  assign wr_go = awvalid_i && wvalid_i && !bvalid_o && !wr_rdy_q;
  assign rd_go = arvalid_i && !rvalid_o && !rd_rdy_q && !wr_go;  // write wins

  always_ff @(posedge s_axi_aclk) begin
    if (reset_i) begin
      wr_rdy_q <= 1'b0;
      rd_rdy_q <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
      req_o    <= '0;
    end else begin
      wr_rdy_q <= wr_go;
      rd_rdy_q <= rd_go;
      req_o.we <= wr_go;
      req_o.re <= rd_go;
      if (wr_go) begin
        req_o.addr <= awaddr_i[adrv_pkg::ADDR_W-1:2];
        req_o.data <= wdata_i;
        req_o.strb <= wstrb_i;
      end else if (rd_go) begin
        req_o.addr <= araddr_i[adrv_pkg::ADDR_W-1:2];
      end
      if (wr_rdy_q)
        bvalid_o <= 1'b1;
      else if (bready_i)
        bvalid_o <= 1'b0;
      if (req_o.re)
        rvalid_o <= 1'b1;
      else if (rready_i)
        rvalid_o <= 1'b0;
    end
  end

  // read data held with rvalid
  always_ff @(posedge s_axi_aclk) begin
    if (req_o.re)
      rdata_o <= rdata_i;
  end

  assign awready_o = wr_rdy_q;
  assign wready_o  = wr_rdy_q;
  assign arready_o = rd_rdy_q;
  assign bresp_o   = 2'b00;  // always OKAY
  assign rresp_o   = 2'b00;

  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o);

endmodule

/* adrv_pkg.sv */
package adrv_pkg;

  // ************************************************************
  // widths
  // ************************************************************
  localparam int ADDR_W   = 7;
  localparam int WADDR_W  = ADDR_W - 2;  // word address
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int DELAY_W  = 16;
  localparam int DGPIO_W  = 16;
  localparam int NUM_CHAN = 4;  // rx1, rx2, tx1, tx2

  localparam logic [DGPIO_W-1:0] DGPIO_DIR_RST = '1;  // all inputs

  localparam int SPI_DIV   = 4;  // cycles per half spi clock
  localparam int SPI_DIV_W = $clog2(SPI_DIV);
  localparam logic [SPI_DIV_W-1:0] SPI_DIV_LAST = SPI_DIV_W'(SPI_DIV - 1);

  // ************************************************************
  // register map, byte offsets
  // ************************************************************
  localparam logic [ADDR_W-1:0] REG_CTRL       = 7'h00;
  localparam logic [ADDR_W-1:0] REG_DGPIO_DIR  = 7'h04;
  localparam logic [ADDR_W-1:0] REG_DGPIO_OUT  = 7'h08;
  localparam logic [ADDR_W-1:0] REG_DGPIO_IN   = 7'h0C;
  localparam logic [ADDR_W-1:0] REG_DELAY_BASE = 7'h10;
  localparam logic [ADDR_W-1:0] REG_SPI_TX     = 7'h20;
  localparam logic [ADDR_W-1:0] REG_SPI_STAT   = 7'h24;

  // rstn, modes 7:4, sw enables 11:8
  localparam logic [DATA_W-1:0] CTRL_MASK = 32'h0000_0FF1;

  typedef struct packed {
    logic               we;
    logic               re;
    logic [WADDR_W-1:0] addr;
    logic [DATA_W-1:0]  data;
    logic [STRB_W-1:0]  strb;
  } reg_req_t;

  typedef struct packed {
    logic               mode;    // 1 = fabric pin
    logic               sw_en;
    logic [DELAY_W-1:0] en_dly;
    logic [DELAY_W-1:0] dis_dly;
  } chan_cfg_t;

  typedef struct packed {
    logic       start;
    logic [7:0] data;
  } spi_cmd_t;

  typedef struct packed {
    logic       busy;
    logic       rx_valid;
    logic [7:0] rx_data;
  } spi_stat_t;

endpackage
